//--- design/fetch_pkg.sv
package fetch_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Widths
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef logic [31:0] addr_t;   // Byte address
  typedef logic [31:0] word_t;
  typedef logic [31:0] instr_t;  // Compressed in low half
  typedef logic [29:0] tag_t;    // Word address

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Buses
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    logic  valid;
    tag_t  tag;
    word_t data;
  } fb_entry_t;

  typedef struct packed {
    logic  valid;
    logic  fence;
    addr_t addr;
  } fetch_req_t;

  typedef struct packed {
    logic   ready;
    instr_t instr;
  } fetch_rsp_t;

  typedef struct packed {
    logic  valid;
    logic  fence;
    addr_t addr;
  } imem_req_t;

  typedef struct packed {
    logic  ready;
    word_t rdata;
  } imem_rsp_t;

  typedef struct packed {
    logic       we;
    logic       re;
    logic [0:0] addr;
    word_t      wdata;
  } cfg_req_t;

  localparam logic [0:0] cfg_addr_wait  = 1'b0;
  localparam logic [0:0] cfg_addr_count = 1'b1;

  typedef enum logic {idle, walk} fence_state_e;

endpackage

//--- design/fetchbuffer_data.sv
module fetchbuffer_data import fetch_pkg::*; #(
  parameter int fb_depth = 3
) (
  input  logic                clk,
  input  logic                wen,
  input  logic [fb_depth-1:0] waddr,
  input  fb_entry_t           wentry,
  input  logic [fb_depth-1:0] raddr1,
  input  logic [fb_depth-1:0] raddr2,
  output fb_entry_t           rentry1,
  output fb_entry_t           rentry2
);

  fb_entry_t entries [2**fb_depth];

  // Word of the first halfword and the word after it
  assign rentry1 = entries[raddr1];
  assign rentry2 = entries[raddr2];

  always_ff @(posedge clk) begin
    if (wen) begin
      entries[waddr] <= wentry;
    end
  end

endmodule

//--- design/fetchbuffer_ctrl.sv
module fetchbuffer_ctrl import fetch_pkg::*; #(
  parameter int fb_depth = 3
) (
  input  logic                clk,
  input  logic                rst,
  input  fetch_req_t          fetch_req,
  output fetch_rsp_t          fetch_rsp,
  output imem_req_t           imem_req,
  input  imem_rsp_t           imem_rsp,
  output logic                wen,
  output logic [fb_depth-1:0] waddr,
  output fb_entry_t           wentry,
  output logic [fb_depth-1:0] raddr1,
  output logic [fb_depth-1:0] raddr2,
  input  fb_entry_t           rentry1,
  input  fb_entry_t           rentry2
);

  localparam tag_t n_entries = tag_t'(2**fb_depth);

  fence_state_e        fstate_q, fstate_n;
  logic [fb_depth-1:0] wcnt_q, wcnt_n;
  logic                fence_q, fence_n;
  logic                pend_q, pend_n;
  logic                pf_on_q, pf_on_n;
  addr_t               paddr_q;
  tag_t                pf_tag_q, pf_tag_n;
  tag_t                rsp_tag_q, rsp_tag_n;
  tag_t                drop_q, drop_n;

  addr_t       cur_addr;
  tag_t        tag1, tag2, need_tag, credit;
  tag_t        tag_rx, drop_rx;
  logic        fence_start, fetch_start, fetch_pend;
  logic        rsp_take, fence_done;
  logic        wr_hit1, wr_hit2, have1, have2;
  word_t       data1, data2;
  logic [15:0] half;
  logic        compressed, hit_ok;

  assign fence_start = fetch_req.valid && fetch_req.fence && fstate_q == idle && !fence_q;
  assign fetch_start = fetch_req.valid && !fetch_req.fence;
  assign fetch_pend  = (fetch_start || pend_q) && fstate_q == idle && !fence_q;

  assign cur_addr = fetch_start ? fetch_req.addr : paddr_q;
  assign tag1     = cur_addr[31:2];
  assign tag2     = tag1 + 1'b1;
  assign raddr1   = tag1[fb_depth-1:0];
  assign raddr2   = tag2[fb_depth-1:0];

  assign rsp_take   = imem_rsp.ready && fstate_q == idle && !fence_q;
  assign fence_done = imem_rsp.ready && fstate_q == idle && fence_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Buffer write: fence walk or SRAM reply
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    wen     = 1'b0;
    waddr   = rsp_tag_q[fb_depth-1:0];
    wentry  = '0;
    tag_rx  = rsp_tag_q;
    drop_rx = drop_q;
    if (fstate_q == walk) begin
      wen   = 1'b1;  // Invalid entry
      waddr = wcnt_q;
    end else if (rsp_take) begin
      if (drop_q != '0) begin
        drop_rx = drop_q - 1'b1;  // Stale word from before a redirect
      end else begin
        wen    = 1'b1;
        wentry = '{valid: 1'b1, tag: rsp_tag_q, data: imem_rsp.rdata};
        tag_rx = rsp_tag_q + 1'b1;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Tag match and instruction assembly
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign wr_hit1 = wen && wentry.valid && wentry.tag == tag1;
  assign wr_hit2 = wen && wentry.valid && wentry.tag == tag2;
  assign have1   = wr_hit1 || (rentry1.valid && rentry1.tag == tag1);
  assign have2   = wr_hit2 || (rentry2.valid && rentry2.tag == tag2);
  assign data1   = wr_hit1 ? wentry.data : rentry1.data;
  assign data2   = wr_hit2 ? wentry.data : rentry2.data;

  assign half       = cur_addr[1] ? data1[31:16] : data1[15:0];
  assign compressed = half[1:0] != 2'b11;
  assign hit_ok     = have1 && (compressed || !cur_addr[1] || have2);
  assign need_tag   = have1 ? tag2 : tag1;

  always_comb begin
    if (compressed) begin
      fetch_rsp.instr = {16'h0000, half};
    end else if (cur_addr[1]) begin
      fetch_rsp.instr = {data2[15:0], half};  // Straddles two words
    end else begin
      fetch_rsp.instr = data1;
    end
  end

  assign fetch_rsp.ready = (fetch_pend && hit_ok) || fence_done;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Fence walk, redirect and prefetch
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    fstate_n  = fstate_q;
    wcnt_n    = wcnt_q;
    fence_n   = fence_q;
    pf_on_n   = pf_on_q;
    pend_n    = fetch_pend && !hit_ok;
    drop_n    = drop_rx;
    rsp_tag_n = tag_rx;
    pf_tag_n  = pf_tag_q;
    imem_req  = '0;
    if (fence_start) begin
      fstate_n = walk;
      wcnt_n   = '0;
      fence_n  = 1'b1;
      pf_on_n  = 1'b0;
    end
    if (fstate_q == walk) begin
      wcnt_n = wcnt_q + 1'b1;
      if (wcnt_q == '1) begin
        fstate_n       = idle;
        imem_req.fence = fence_q;  // None after the reset walk
        drop_n         = '0;
        rsp_tag_n      = pf_tag_q;
      end
    end
    if (fence_done) begin
      fence_n = 1'b0;
    end
    if (fetch_start) begin
      pf_on_n = 1'b1;
    end
    // Missing word neither in flight nor next to issue
    if (fetch_pend && !hit_ok && (need_tag - tag_rx) > (pf_tag_q - tag_rx)) begin
      drop_n    = drop_rx + (pf_tag_q - tag_rx);
      pf_tag_n  = need_tag;
      rsp_tag_n = need_tag;
    end
    credit = pf_tag_n - tag1;  // Words ahead of the current one
    if (pf_on_n && fstate_q == idle && !fence_q && !fence_start && credit < n_entries) begin
      imem_req.valid = 1'b1;
      imem_req.addr  = {pf_tag_n, 2'b00};
      pf_tag_n       = pf_tag_n + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      fstate_q  <= walk;  // Clear the buffer out of reset
      wcnt_q    <= '0;
      fence_q   <= 1'b0;
      pend_q    <= 1'b0;
      pf_on_q   <= 1'b0;
      pf_tag_q  <= '0;
      rsp_tag_q <= '0;
      drop_q    <= '0;
    end else begin
      fstate_q  <= fstate_n;
      wcnt_q    <= wcnt_n;
      fence_q   <= fence_n;
      pend_q    <= pend_n;
      pf_on_q   <= pf_on_n;
      pf_tag_q  <= pf_tag_n;
      rsp_tag_q <= rsp_tag_n;
      drop_q    <= drop_n;
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_start) begin
      paddr_q <= fetch_req.addr;
    end
  end

endmodule

//--- design/imem_sram.sv
module imem_sram import fetch_pkg::*; #(
  parameter int imem_aw = 10,
  parameter int max_wait = 3,
  localparam int wait_w = (max_wait > 0) ? $clog2(max_wait + 1) : 1
) (
  input  logic               clk,
  input  logic               rst,
  input  imem_req_t          imem_req,
  output imem_rsp_t          imem_rsp,
  input  logic [wait_w-1:0]  wait_cycles,
  input  logic               load_en,
  input  logic [imem_aw-1:0] load_addr,
  input  word_t              load_data
);

  word_t     mem [2**imem_aw];
  imem_rsp_t pipe [max_wait+1];
  logic      pipe_fence [max_wait+1];

  always_ff @(posedge clk) begin
    if (load_en) begin
      mem[load_addr] <= load_data;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Read pipeline, one stage per wait state
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    pipe[0].rdata <= mem[imem_req.addr[imem_aw+1:2]];
    pipe_fence[0] <= imem_req.fence;
    for (int i = 1; i <= max_wait; i++) begin
      pipe[i].rdata <= pipe[i-1].rdata;
      pipe_fence[i] <= pipe_fence[i-1];
    end
    if (!rst) begin
      for (int i = 0; i <= max_wait; i++) begin
        pipe[i].ready <= 1'b0;
      end
    end else begin
      pipe[0].ready <= imem_req.valid || imem_req.fence;
      for (int i = 1; i <= max_wait; i++) begin
        pipe[i].ready <= pipe[i-1].ready && !imem_req.fence;  // Fence drops reads in flight
      end
    end
  end

  assign imem_rsp.ready = pipe[wait_cycles].ready;
  assign imem_rsp.rdata = pipe_fence[wait_cycles] ? '0 : pipe[wait_cycles].rdata;

endmodule

//--- design/fetch_cfg.sv
module fetch_cfg import fetch_pkg::*; #(
  parameter int max_wait = 3,
  localparam int wait_w = (max_wait > 0) ? $clog2(max_wait + 1) : 1
) (
  input  logic              clk,
  input  logic              rst,
  input  cfg_req_t          cfg_req,
  output word_t             cfg_rdata,
  input  logic              instr_done,
  output logic [wait_w-1:0] wait_cycles
);

  word_t count_q;

  always_ff @(posedge clk) begin
    if (!rst) begin
      wait_cycles <= '0;
      count_q     <= '0;
      cfg_rdata   <= '0;
    end else begin
      if (cfg_req.we && cfg_req.addr == cfg_addr_wait) begin
        if (cfg_req.wdata > word_t'(max_wait)) begin
          wait_cycles <= wait_w'(max_wait);  // Clamp
        end else begin
          wait_cycles <= cfg_req.wdata[wait_w-1:0];
        end
      end
      if (cfg_req.we && cfg_req.addr == cfg_addr_count) begin
        count_q <= '0;
      end else if (instr_done) begin
        count_q <= count_q + 1'b1;  // Wraps
      end
      if (cfg_req.re) begin
        cfg_rdata <= (cfg_req.addr == cfg_addr_wait) ? word_t'(wait_cycles) : count_q;
      end
    end
  end

endmodule

//--- design/fetch_top.sv
module fetch_top import fetch_pkg::*; #(
  parameter int fb_depth = 3,
  parameter int imem_aw = 10,
  parameter int max_wait = 3
) (
  input  logic               clk,
  input  logic               rst,
  input  fetch_req_t         fetch_req,
  output fetch_rsp_t         fetch_rsp,
  input  cfg_req_t           cfg_req,
  output word_t              cfg_rdata,
  input  logic               load_en,
  input  logic [imem_aw-1:0] load_addr,
  input  word_t              load_data
);

  localparam int wait_w = (max_wait > 0) ? $clog2(max_wait + 1) : 1;

  imem_req_t           imem_req;
  imem_rsp_t           imem_rsp;
  logic                wen;
  logic [fb_depth-1:0] waddr, raddr1, raddr2;
  fb_entry_t           wentry, rentry1, rentry2;
  logic [wait_w-1:0]   wait_cycles;

  fetchbuffer_ctrl #(.fb_depth(fb_depth)) u_ctrl (
    .clk(clk), .rst(rst),
    .fetch_req(fetch_req), .fetch_rsp(fetch_rsp),
    .imem_req(imem_req), .imem_rsp(imem_rsp),
    .wen(wen), .waddr(waddr), .wentry(wentry),
    .raddr1(raddr1), .raddr2(raddr2),
    .rentry1(rentry1), .rentry2(rentry2)
  );

  fetchbuffer_data #(.fb_depth(fb_depth)) u_data (
    .clk(clk), .wen(wen), .waddr(waddr), .wentry(wentry),
    .raddr1(raddr1), .raddr2(raddr2),
    .rentry1(rentry1), .rentry2(rentry2)
  );

  imem_sram #(.imem_aw(imem_aw), .max_wait(max_wait)) u_sram (
    .clk(clk), .rst(rst),
    .imem_req(imem_req), .imem_rsp(imem_rsp),
    .wait_cycles(wait_cycles),
    .load_en(load_en), .load_addr(load_addr), .load_data(load_data)
  );

  fetch_cfg #(.max_wait(max_wait)) u_cfg (
    .clk(clk), .rst(rst),
    .cfg_req(cfg_req), .cfg_rdata(cfg_rdata),
    .instr_done(fetch_rsp.ready),  // Counts delivered instructions
    .wait_cycles(wait_cycles)
  );

endmodule

//--- dv/fetch_assert.sv
module fetch_ctrl_assert import fetch_pkg::*; (
  input logic         clk,
  input logic         rst,
  input fetch_req_t   fetch_req,
  input fetch_rsp_t   fetch_rsp,
  input imem_req_t    imem_req,
  input fence_state_e fstate_q
);

  logic open_q;  // Request still waiting for ready
  int   fail_cnt = 0;

  always_ff @(posedge clk) begin
    if (!rst) begin
      open_q <= 1'b0;
    end else begin
      open_q <= (open_q || fetch_req.valid) && !fetch_rsp.ready;
    end
  end

  no_ready_in_walk: assert property (@(posedge clk) disable iff (!rst)
    fstate_q == walk |-> !fetch_rsp.ready)
    else begin
      $error("fetch ready raised during fence walk");
      fail_cnt++;
    end

  no_valid_with_fence: assert property (@(posedge clk) disable iff (!rst)
    !(imem_req.valid && imem_req.fence))
    else begin
      $error("SRAM read and fence requested together");
      fail_cnt++;
    end

  quiet_after_reset: assert property (@(posedge clk)
    !rst |=> !fetch_rsp.ready && !imem_req.valid)
    else begin
      $error("ready or SRAM valid high right after reset");
      fail_cnt++;
    end

  ready_answers_request: assert property (@(posedge clk) disable iff (!rst)
    fetch_rsp.ready |-> open_q || fetch_req.valid)
    else begin
      $error("ready without an open request");
      fail_cnt++;
    end

  request_after_ready: assert property (@(posedge clk) disable iff (!rst)
    fetch_req.valid |-> !open_q)
    else begin
      $error("new request before ready of the previous one");
      fail_cnt++;
    end

endmodule

bind fetchbuffer_ctrl fetch_ctrl_assert u_ctrl_assert (.*);

//--- dv/fetch_tb.sv
module fetch_tb import fetch_pkg::*; ();

  localparam int fb_depth  = 3;
  localparam int imem_aw   = 10;
  localparam int max_wait  = 3;
  localparam int n_words   = 64;
  localparam int n_seq     = 16;  // Aligned 32-bit region
  localparam int n_jump    = 40;
  localparam int n_refetch = 8;
  localparam int n_wjump   = 16;  // Jumps per wait count
  localparam int n_req     = n_seq + 2 * (n_words - 1 - n_seq) + n_jump + 2 * n_refetch + 1
                             + max_wait * n_wjump;
  localparam int limit     = n_req * (max_wait + 2) * 4 + 2**fb_depth;

  logic               clk = 1'b0;
  logic               rst;
  fetch_req_t         fetch_req;
  fetch_rsp_t         fetch_rsp;
  cfg_req_t           cfg_req;
  word_t              cfg_rdata;
  logic               load_en;
  logic [imem_aw-1:0] load_addr;
  word_t              load_data;

  word_t  image [n_words];
  word_t  rng = 32'd54;
  instr_t exp_q [$];
  int     kind_q [$];  // 0 full, 1 compressed, 2 fence
  instr_t exp_instr;
  int     exp_kind;
  int     issued = 0;
  int     done = 0;
  int     fetch_cnt = 0;
  int     checks = 0;
  int     errors = 0;
  string  test_name = "reset";
  word_t  rd;

  fetch_top #(.fb_depth(fb_depth), .imem_aw(imem_aw), .max_wait(max_wait)) DUT (.*);

  always #5 clk = ~clk;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Program model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic word_t xorshift();
    rng ^= rng << 13;
    rng ^= rng >> 17;
    rng ^= rng << 5;
    return rng;
  endfunction

  function automatic logic [15:0] half_at(addr_t a);
    word_t w;
    w = image[a[31:2]];
    return a[1] ? w[31:16] : w[15:0];
  endfunction

  function automatic instr_t ref_instr(addr_t a);
    logic [15:0] lo;
    lo = half_at(a);
    if (lo[1:0] != 2'b11) begin
      return {16'h0000, lo};
    end
    return {half_at(a + 2), lo};
  endfunction

  function automatic addr_t rand_addr();
    return addr_t'((xorshift() % ((n_words - 1) * 2)) * 2);  // Halfword, straddle in range
  endfunction

  task automatic build_image();
    word_t w;
    for (int i = 0; i < n_words; i++) begin
      w = xorshift();
      if (i < n_seq) begin
        w[1:0] = 2'b11;
      end else begin
        w[1:0]   = w[4] ? 2'b11 : 2'b01;  // Mixed encodings
        w[17:16] = w[5] ? 2'b11 : 2'b10;
      end
      image[i] = w;
    end
  endtask

  task automatic load_image();
    for (int i = 0; i < n_words; i++) begin
      load_en   = 1'b1;
      load_addr = imem_aw'(i);
      load_data = image[i];
      @(negedge clk);
    end
    load_en = 1'b0;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic issue(fetch_req_t req, instr_t exp, int kind);
    exp_q.push_back(exp);
    kind_q.push_back(kind);
    issued++;
    fetch_req = req;
    @(negedge clk);
    fetch_req = '0;
    while (done < issued) begin
      @(negedge clk);
    end
  endtask

  task automatic fetch_instr(addr_t a);
    instr_t exp;
    exp = ref_instr(a);
    fetch_cnt++;
    issue('{valid: 1'b1, fence: 1'b0, addr: a}, exp, (exp[1:0] != 2'b11) ? 1 : 0);
  endtask

  task automatic fence_buffer();
    issue('{valid: 1'b1, fence: 1'b1, addr: '0}, '0, 2);
  endtask

  // Prefetch quiet and every SRAM stage drained
  task automatic settle();
    int quiet;
    quiet = 0;
    while (quiet < max_wait + 2) begin
      @(posedge clk);
      quiet = DUT.imem_req.valid ? 0 : quiet + 1;
    end
    @(negedge clk);
  endtask

  task automatic cfg_write(logic [0:0] a, word_t d);
    cfg_req = '{we: 1'b1, re: 1'b0, addr: a, wdata: d};
    @(negedge clk);
    cfg_req = '0;
  endtask

  task automatic cfg_read(logic [0:0] a, output word_t d);
    cfg_req = '{we: 1'b0, re: 1'b1, addr: a, wdata: '0};
    @(negedge clk);
    cfg_req = '0;
    d = cfg_rdata;
  endtask

  task automatic check_instr(string name, instr_t exp, instr_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_reg(string name, word_t exp, word_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  always @(posedge clk) begin
    if (rst && fetch_rsp.ready) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("Unexpected ready in %s with no request outstanding", test_name);
      end else begin
        exp_instr = exp_q.pop_front();
        exp_kind  = kind_q.pop_front();
        if (exp_kind == 1) begin
          check_instr(test_name, {16'h0000, exp_instr[15:0]},
                      {16'h0000, fetch_rsp.instr[15:0]});
        end else if (exp_kind == 0) begin
          check_instr(test_name, exp_instr, fetch_rsp.instr);
        end
      end
      done++;
    end
  end

  initial begin
    repeat (limit) @(posedge clk);
    $display("Timeout after %0d cycles with %0d requests unanswered", limit, issued - done);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    rst       = 1'b0;
    fetch_req = '0;
    cfg_req   = '0;
    load_en   = 1'b0;
    load_addr = '0;
    load_data = '0;
    repeat (10) @(negedge clk);
    rst = 1'b1;
    build_image();
    load_image();
    repeat (2**fb_depth) @(negedge clk);  // Reset walk

    test_name = "seq_aligned";
    for (int i = 0; i < n_seq; i++) begin
      fetch_instr(addr_t'(i * 4));
    end
    test_name = "mixed";
    for (int a = n_seq * 4; a < (n_words - 1) * 4; a += 2) begin
      fetch_instr(addr_t'(a));
    end
    test_name = "jumps";
    repeat (n_jump) fetch_instr(rand_addr());

    test_name = "fence";
    for (int i = n_seq - 1; i >= n_seq - n_refetch; i--) begin
      fetch_instr(addr_t'(i * 4));  // Descending leaves exactly these words buffered
    end
    settle();
    build_image();  // New image behind stale buffer
    load_image();
    fence_buffer();
    for (int i = n_seq - n_refetch; i < n_seq; i++) begin
      fetch_instr(addr_t'(i * 4));
    end

    test_name = "wait";
    settle();
    cfg_write(cfg_addr_count, '0);
    fetch_cnt = 0;
    for (int w = 1; w <= max_wait; w++) begin
      settle();
      cfg_write(cfg_addr_wait, word_t'(w));
      cfg_read(cfg_addr_wait, rd);
      check_reg("wait_readback", word_t'(w), rd);
      repeat (n_wjump) fetch_instr(rand_addr());
    end
    settle();
    cfg_write(cfg_addr_wait, word_t'(max_wait + 2));
    cfg_read(cfg_addr_wait, rd);
    check_reg("wait_clamp", word_t'(max_wait), rd);
    cfg_read(cfg_addr_count, rd);
    check_reg("instr_count", word_t'(fetch_cnt), rd);

    $display("%0d checks, %0d errors, %0d assertion failures", checks, errors,
             DUT.u_ctrl.u_ctrl_assert.fail_cnt);
    if (errors == 0 && DUT.u_ctrl.u_ctrl_assert.fail_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- fetch.f
design/fetch_pkg.sv
design/fetchbuffer_data.sv
design/fetchbuffer_ctrl.sv
design/imem_sram.sv
design/fetch_cfg.sv
design/fetch_top.sv
dv/fetch_assert.sv
dv/fetch_tb.sv

//--- Bender.yml
package:
  name: fetch

sources:
  - design/fetch_pkg.sv
  - design/fetchbuffer_data.sv
  - design/fetchbuffer_ctrl.sv
  - design/imem_sram.sv
  - design/fetch_cfg.sv
  - design/fetch_top.sv
  - target: test
    files:
      - dv/fetch_assert.sv
      - dv/fetch_tb.sv
